// ==== hid_mon_pkg.sv ====
// **********************************************************************
// hid monitor package
// shared widths, data types and display colours
// **********************************************************************
`default_nettype none

package hid_mon_pkg;

  localparam int N_PORTS          = 3;
  localparam int SLOT_BITS        = 64;  // report bits shown per port
  localparam int DIGITS_PER_ROW   = 16;
  localparam int MIN_REPORT_BYTES = 8;   // shortest report in non-strict mode

  typedef logic [7:0]                   byte_t;
  typedef logic [SLOT_BITS-1:0]         slot_t;
  typedef logic [N_PORTS*SLOT_BITS-1:0] disp_t;   // port p at bits 64p +: 64
  typedef logic [15:0]                  color_t;  // rgb565

  // screen is 96 x 24, 6x8 cells
  typedef logic [6:0] pix_x_t;
  typedef logic [4:0] pix_y_t;

  localparam color_t FG_COLOR = 16'hffff;  // white
  localparam color_t BG_COLOR = 16'h0000;  // black

endpackage

`default_nettype wire

// ==== hid_report_collector.sv ====
// **********************************************************************
// hid report collector
// assembles one port's byte stream into a report and checks its length
// **********************************************************************
`timescale 1ns/10ps
`default_nettype none

module hid_report_collector
  import hid_mon_pkg::*;
#(
  parameter int report_bytes  = 20,
  parameter bit length_strict = 1'b0
)
(
  input  wire logic                      clk_usb,
  input  wire logic                      arst_n,
  input  wire byte_t                     rx_byte,
  input  wire logic                      rx_strobe,
  input  wire logic                      rx_eop,
  input  wire logic                      rx_error,
  output logic [report_bytes*8-1:0]      report,
  output logic                           report_valid
);

  // counter saturates one past report_bytes so overlong packets stay visible
  localparam int cnt_w = $clog2(report_bytes + 2);
  localparam logic [cnt_w-1:0] cnt_full = cnt_w'(report_bytes);
  localparam logic [cnt_w-1:0] cnt_sat  = cnt_w'(report_bytes + 1);
  localparam logic [cnt_w-1:0] cnt_min  = cnt_w'(MIN_REPORT_BYTES);

  byte_t [report_bytes-1:0] shadow;   // bytes of the packet in progress
  logic [cnt_w-1:0]         byte_cnt;
  logic                     err_flag;
  logic                     err_any;
  logic                     len_ok;
  logic                     accept;

  assign err_any = err_flag | rx_error;   // error may also show in the eop cycle
  assign len_ok  = length_strict ? (byte_cnt == cnt_full) : (byte_cnt >= cnt_min);
  assign accept  = rx_eop & ~err_any & len_ok;

  always_ff @(posedge clk_usb or negedge arst_n)
  begin
    if (!arst_n)
    begin
      byte_cnt     <= '0;
      err_flag     <= 1'b0;
      report_valid <= 1'b0;
    end
    else
    begin
      report_valid <= accept;
      if (rx_eop)
      begin
        // start over for the next packet, accepted or not
        byte_cnt <= '0;
        err_flag <= 1'b0;
      end
      else
      begin
        err_flag <= err_any;
        if (rx_strobe && byte_cnt != cnt_sat)
          byte_cnt <= byte_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_usb)
  begin
    if (rx_strobe && byte_cnt < cnt_full)
      shadow[byte_cnt] <= rx_byte;  // extra bytes are dropped
    if (accept)
      report <= shadow;
  end

endmodule

`default_nettype wire

// ==== report_display_latch.sv ====
// **********************************************************************
// report display latch
// holds one 64-bit display slot per port, loaded from accepted reports
// **********************************************************************
`timescale 1ns/10ps
`default_nettype none

module report_display_latch
  import hid_mon_pkg::*;
(
  input  wire logic                       clk_usb,
  input  wire logic                       arst_n,
  input  wire slot_t [N_PORTS-1:0]        slot_in,
  input  wire logic  [N_PORTS-1:0]        slot_load,
  output disp_t                           disp
);

  slot_t [N_PORTS-1:0] slot_q;

  // one register per port, so simultaneous loads never collide
  for (genvar p = 0; p < N_PORTS; p++)
  begin : g_slot
    always_ff @(posedge clk_usb or negedge arst_n)
    begin
      if (!arst_n)
        slot_q[p] <= '0;  // screen shows zeros after reset
      else if (slot_load[p])
        slot_q[p] <= slot_in[p];
    end
  end

  assign disp = slot_q;  // port p lands at bits 64p +: 64

endmodule

`default_nettype wire

// ==== hex_font_rom.sv ====
// **********************************************************************
// hex font rom
// 5x7 glyphs for the digits 0 to F, row 7 left blank
// **********************************************************************
`timescale 1ns/10ps
`default_nettype none

module hex_font_rom
(
  input  wire logic [3:0] digit,
  input  wire logic [2:0] glyph_row,
  output logic      [4:0] row_bits   // bit 4 is the leftmost column
);

  logic [34:0] glyph;  // row 0 in the top five bits

  always_comb
  begin
    case (digit)
      4'h0: glyph = {5'b01110, 5'b10001, 5'b10011, 5'b10101, 5'b11001, 5'b10001, 5'b01110};
      4'h1: glyph = {5'b00100, 5'b01100, 5'b00100, 5'b00100, 5'b00100, 5'b00100, 5'b01110};
      4'h2: glyph = {5'b01110, 5'b10001, 5'b00001, 5'b00010, 5'b00100, 5'b01000, 5'b11111};
      4'h3: glyph = {5'b11111, 5'b00010, 5'b00100, 5'b00010, 5'b00001, 5'b10001, 5'b01110};
      4'h4: glyph = {5'b00010, 5'b00110, 5'b01010, 5'b10010, 5'b11111, 5'b00010, 5'b00010};
      4'h5: glyph = {5'b11111, 5'b10000, 5'b11110, 5'b00001, 5'b00001, 5'b10001, 5'b01110};
      4'h6: glyph = {5'b00110, 5'b01000, 5'b10000, 5'b11110, 5'b10001, 5'b10001, 5'b01110};
      4'h7: glyph = {5'b11111, 5'b00001, 5'b00010, 5'b00100, 5'b01000, 5'b01000, 5'b01000};
      4'h8: glyph = {5'b01110, 5'b10001, 5'b10001, 5'b01110, 5'b10001, 5'b10001, 5'b01110};
      4'h9: glyph = {5'b01110, 5'b10001, 5'b10001, 5'b01111, 5'b00001, 5'b00010, 5'b01100};
      4'ha: glyph = {5'b01110, 5'b10001, 5'b10001, 5'b11111, 5'b10001, 5'b10001, 5'b10001};
      4'hb: glyph = {5'b11110, 5'b10001, 5'b10001, 5'b11110, 5'b10001, 5'b10001, 5'b11110};
      4'hc: glyph = {5'b01110, 5'b10001, 5'b10000, 5'b10000, 5'b10000, 5'b10001, 5'b01110};
      4'hd: glyph = {5'b11100, 5'b10010, 5'b10001, 5'b10001, 5'b10001, 5'b10010, 5'b11100};
      4'he: glyph = {5'b11111, 5'b10000, 5'b10000, 5'b11110, 5'b10000, 5'b10000, 5'b11111};
      default: glyph = {5'b11111, 5'b10000, 5'b10000, 5'b11110, 5'b10000, 5'b10000, 5'b10000};
    endcase
  end

  always_comb
  begin
    if (glyph_row == 3'd7)
      row_bits = 5'b00000;  // spacing row between text lines
    else
      row_bits = glyph[(3'd6 - glyph_row)*5 +: 5];
  end

endmodule

`default_nettype wire

// ==== hex_glyph_decoder.sv ====
// **********************************************************************
// hex glyph decoder
// two-stage pipeline from pixel coordinates to an rgb565 colour
// **********************************************************************
`timescale 1ns/10ps
`default_nettype none

module hex_glyph_decoder
  import hid_mon_pkg::*;
(
  input  wire logic   clk_usb,
  input  wire logic   arst_n,
  input  wire disp_t  disp,
  input  wire pix_x_t pixel_x,
  input  wire pix_y_t pixel_y,
  output color_t      pixel_color
);

  slot_t [N_PORTS-1:0] slots;
  slot_t               row_slot;
  pix_x_t              cell_col;   // x / 6
  pix_x_t              cell_x;     // x mod 6
  logic [1:0]          scr_row;
  logic                on_screen;
  logic [3:0]          nibble;

  // stage 1 registers
  logic [3:0] digit_q;
  logic [2:0] glyph_row_q;
  logic [2:0] cell_x_q;
  logic       on_screen_q;

  logic [4:0] row_bits;
  logic       glyph_bit;

  assign slots = disp;

  always_comb
  begin
    cell_col  = pixel_x / 7'd6;
    cell_x    = pixel_x % 7'd6;
    scr_row   = pixel_y[4:3];
    on_screen = (cell_col < 7'(DIGITS_PER_ROW)) && (scr_row < 2'(N_PORTS));
    row_slot  = on_screen ? slots[scr_row] : '0;
    // reversed scan, least significant nibble on the left
    nibble    = row_slot[cell_col[3:0]*4 +: 4];
  end

  always_ff @(posedge clk_usb or negedge arst_n)
  begin
    if (!arst_n)
    begin
      digit_q     <= '0;
      glyph_row_q <= '0;
      cell_x_q    <= '0;
      on_screen_q <= 1'b0;
    end
    else
    begin
      digit_q     <= nibble;
      glyph_row_q <= pixel_y[2:0];
      cell_x_q    <= cell_x[2:0];
      on_screen_q <= on_screen;
    end
  end

  hex_font_rom hex_font_rom_i
  (
    .digit     (digit_q),
    .glyph_row (glyph_row_q),
    .row_bits  (row_bits)
  );

  // column 5 of each cell is the gap between digits
  assign glyph_bit = (cell_x_q < 3'd5) && row_bits[3'd4 - cell_x_q];

  always_ff @(posedge clk_usb or negedge arst_n)
  begin
    if (!arst_n)
      pixel_color <= BG_COLOR;
    else
      pixel_color <= (on_screen_q && glyph_bit) ? FG_COLOR : BG_COLOR;
  end

endmodule

`default_nettype wire

// ==== usb_hid_monitor.sv ====
// **********************************************************************
// usb hid monitor top level
// three report collectors, display latch and hex glyph decoder
// **********************************************************************
`timescale 1ns/10ps
`default_nettype none

module usb_hid_monitor
  import hid_mon_pkg::*;
#(
  parameter int report_bytes  = 20,  // 8 for a plain gamepad, 20 for xbox360
  parameter bit length_strict = 1'b0
)
(
  input  wire logic                clk_usb,
  input  wire logic                arst_n,
  input  wire byte_t [N_PORTS-1:0] rx_byte,
  input  wire logic  [N_PORTS-1:0] rx_strobe,
  input  wire logic  [N_PORTS-1:0] rx_eop,
  input  wire logic  [N_PORTS-1:0] rx_error,
  input  wire pix_x_t              pixel_x,
  input  wire pix_y_t              pixel_y,
  output logic       [N_PORTS-1:0] report_valid,
  output color_t                   pixel_color
);

  logic [report_bytes*8-1:0] report [N_PORTS];
  slot_t [N_PORTS-1:0]       slot_in;
  disp_t                     disp;

  for (genvar p = 0; p < N_PORTS; p++)
  begin : g_port
    hid_report_collector #(
      .report_bytes  (report_bytes),
      .length_strict (length_strict)
    ) hid_report_collector_i
    (
      .clk_usb      (clk_usb),
      .arst_n       (arst_n),
      .rx_byte      (rx_byte[p]),
      .rx_strobe    (rx_strobe[p]),
      .rx_eop       (rx_eop[p]),
      .rx_error     (rx_error[p]),
      .report       (report[p]),
      .report_valid (report_valid[p])
    );

    assign slot_in[p] = report[p][SLOT_BITS-1:0];  // first 8 bytes go on screen
  end

  report_display_latch report_display_latch_i
  (
    .clk_usb   (clk_usb),
    .arst_n    (arst_n),
    .slot_in   (slot_in),
    .slot_load (report_valid),
    .disp      (disp)
  );

  hex_glyph_decoder hex_glyph_decoder_i
  (
    .clk_usb     (clk_usb),
    .arst_n      (arst_n),
    .disp        (disp),
    .pixel_x     (pixel_x),
    .pixel_y     (pixel_y),
    .pixel_color (pixel_color)
  );

endmodule

`default_nettype wire

// ==== usb_hid_monitor_asserts.sv ====
// **********************************************************************
// usb hid monitor assertions
// report_valid pulse rules and a known pixel colour after reset
// **********************************************************************
`timescale 1ns/10ps
`default_nettype none

module usb_hid_monitor_asserts
  import hid_mon_pkg::*;
(
  input wire logic               clk_usb,
  input wire logic               arst_n,
  input wire logic [N_PORTS-1:0] rx_eop,
  input wire logic [N_PORTS-1:0] report_valid,
  input wire color_t             pixel_color
);

  for (genvar p = 0; p < N_PORTS; p++)
  begin : g_port
    // one-cycle pulse per accepted report
    assert property (@(posedge clk_usb) disable iff (!arst_n)
      report_valid[p] |=> !report_valid[p])
    else $error("report_valid[%0d] high for two cycles in a row", p);

    assert property (@(posedge clk_usb) disable iff (!arst_n)
      report_valid[p] |-> $past(rx_eop[p]))  // latency of one cycle from eop
    else $error("report_valid[%0d] high without rx_eop in the cycle before", p);
  end

  assert property (@(posedge clk_usb) disable iff (!arst_n) !$isunknown(pixel_color))
  else $error("pixel_color is unknown after reset");

endmodule

`default_nettype wire

// ==== tb_usb_hid_monitor.sv ====
// **********************************************************************
// usb hid monitor testbench
// packet and pixel stimulus from the pattern file, checked against it
// **********************************************************************
`timescale 1ns/10ps
`default_nettype none

module tb_usb_hid_monitor
  import hid_mon_pkg::*;
();

  localparam int PAT_DEPTH = 1024;
  localparam int MAX_BYTES = 32;

  logic                clk_usb;
  logic                arst_n;
  byte_t [N_PORTS-1:0] rx_byte;
  logic  [N_PORTS-1:0] rx_strobe;
  logic  [N_PORTS-1:0] rx_eop;
  logic  [N_PORTS-1:0] rx_error;
  pix_x_t              pixel_x;
  pix_y_t              pixel_y;
  logic  [N_PORTS-1:0] report_valid;
  color_t              pixel_color;

  logic [31:0]        pat_mem [PAT_DEPTH];
  logic [31:0]        lfsr_state;
  int                 cycle_cnt;
  int                 cycle_limit;
  // packets wait here until a send record
  byte_t              pkt_bytes [N_PORTS][MAX_BYTES];
  int                 pkt_len [N_PORTS];
  logic               pkt_err [N_PORTS];
  logic [N_PORTS-1:0] pkt_acc;
  logic [N_PORTS-1:0] pkt_pend;
  slot_t              slot_model [N_PORTS];  // bytes 0 to 7 of the last accepted report
  pix_x_t             px_q [$];
  pix_y_t             py_q [$];
  color_t             pc_q [$];

  usb_hid_monitor usb_hid_monitor_i
  (
    .clk_usb      (clk_usb),
    .arst_n       (arst_n),
    .rx_byte      (rx_byte),
    .rx_strobe    (rx_strobe),
    .rx_eop       (rx_eop),
    .rx_error     (rx_error),
    .pixel_x      (pixel_x),
    .pixel_y      (pixel_y),
    .report_valid (report_valid),
    .pixel_color  (pixel_color)
  );

  bind usb_hid_monitor usb_hid_monitor_asserts usb_hid_monitor_asserts_i
  (
    .clk_usb      (clk_usb),
    .arst_n       (arst_n),
    .rx_eop       (rx_eop),
    .report_valid (report_valid),
    .pixel_color  (pixel_color)
  );

  initial
  begin
    clk_usb = 1'b0;
    forever #4 clk_usb = ~clk_usb;
  end

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);  // galois, taps 32 22 2 1
  endfunction

  function automatic int draw_bits(input int n);
    logic [31:0] bits;
    bits = '0;
    for (int i = 0; i < n; i++)
    begin
      bits       = {bits[30:0], lfsr_state[0]};
      lfsr_state = lfsr_next(lfsr_state);
    end
    return int'(bits);
  endfunction

  // walks the records to size the timeout
  function automatic int pattern_words();
    int i;
    i = 0;
    while (i < PAT_DEPTH && pat_mem[i] != 0)
    begin
      if (pat_mem[i] == 32'd1)
        i = i + 5 + pat_mem[i+4];
      else if (pat_mem[i] == 32'd3)
        i = i + 4;
      else
        i = i + 1;
    end
    return i;
  endfunction

  task automatic stop_run();
    $display("RESULT: FAIL");
    $fatal(1, "simulation stopped on the first error");
  endtask

  task automatic step();
    @(posedge clk_usb);
    #1;
  endtask

  task automatic check_valid(input logic [N_PORTS-1:0] exp);
    assert (report_valid == exp)
    else
    begin
      $display("Fail %0t report_valid got %b expected %b", $time, report_valid, exp);
      stop_run();
    end
  endtask

  task automatic send_packets();
    int   pos [N_PORTS];
    int   gap [N_PORTS];
    logic busy;
    for (int p = 0; p < N_PORTS; p++)
    begin
      pos[p] = 0;
      gap[p] = 0;
    end
    busy = 1'b1;
    while (busy)
    begin
      step();
      check_valid('0);
      busy      = 1'b0;
      rx_strobe = '0;
      rx_error  = '0;
      for (int p = 0; p < N_PORTS; p++)
      begin
        if (pkt_pend[p] && pos[p] < pkt_len[p])
        begin
          busy = 1'b1;
          if (gap[p] > 0)
            gap[p]--;
          else
          begin
            rx_byte[p]   = pkt_bytes[p][pos[p]];
            rx_strobe[p] = 1'b1;
            rx_error[p]  = pkt_err[p] && (pos[p] == pkt_len[p] / 2);
            pos[p]++;
            gap[p] = draw_bits(2);  // 0 to 3 idle cycles
          end
        end
      end
    end
    rx_eop = pkt_pend;  // all pending packets end together
    step();
    rx_eop = '0;
    check_valid(pkt_acc & pkt_pend);
    step();
    check_valid('0);
    for (int p = 0; p < N_PORTS; p++)
    begin
      if (pkt_pend[p] && pkt_acc[p])
        for (int k = 0; k < 8; k++)
          slot_model[p][8*k +: 8] = pkt_bytes[p][k];
      assert (usb_hid_monitor_i.disp[p*SLOT_BITS +: SLOT_BITS] == slot_model[p])
      else
      begin
        $display("Fail %0t disp slot %0d got %h expected %h", $time, p,
                 usb_hid_monitor_i.disp[p*SLOT_BITS +: SLOT_BITS], slot_model[p]);
        stop_run();
      end
    end
    pkt_pend = '0;
  endtask

  // one coordinate per cycle, colour checked two steps later
  task automatic run_pixels();
    int n;
    n = px_q.size();
    for (int k = 0; k < n + 2; k++)
    begin
      step();
      check_valid('0);
      if (k >= 2)
      begin
        assert (pixel_color == pc_q[k-2])
        else
        begin
          $display("Fail %0t pixel_color got %h expected %h at x %0d y %0d", $time,
                   pixel_color, pc_q[k-2], px_q[k-2], py_q[k-2]);
          stop_run();
        end
      end
      if (k < n)
      begin
        pixel_x = px_q[k];
        pixel_y = py_q[k];
      end
    end
    px_q.delete();
    py_q.delete();
    pc_q.delete();
  endtask

  always @(posedge clk_usb)
  begin
    cycle_cnt++;
    if (cycle_cnt >= cycle_limit)
    begin
      $display("Timeout: the run did not finish within %0d clock cycles", cycle_limit);
      stop_run();
    end
  end

  initial
  begin
    int idx;
    int n;
    int p;
    arst_n      = 1'b0;
    rx_byte     = '0;
    rx_strobe   = '0;
    rx_eop      = '0;
    rx_error    = '0;
    pixel_x     = '0;
    pixel_y     = '0;
    pkt_pend    = '0;
    pkt_acc     = '0;
    lfsr_state  = 32'h8b10;
    cycle_cnt   = 0;
    for (int i = 0; i < N_PORTS; i++)
      slot_model[i] = '0;
    $readmemh("usb_hid_monitor_patterns.txt", pat_mem);
    cycle_limit = pattern_words() * 8 + 1000;
    repeat (5) @(posedge clk_usb);
    #1;
    // outputs held at their reset values
    check_valid('0);
    assert (pixel_color == 16'h0000)
    else
    begin
      $display("Fail %0t pixel_color got %h expected %h in reset", $time,
               pixel_color, 16'h0000);
      stop_run();
    end
    arst_n = 1'b1;
    idx = 0;
    while (pat_mem[idx] != 0)
    begin
      case (pat_mem[idx])
        32'd1:
        begin
          p = pat_mem[idx+1];
          n = pat_mem[idx+4];
          pkt_pend[p] = 1'b1;
          pkt_err[p]  = pat_mem[idx+2][0];
          pkt_acc[p]  = pat_mem[idx+3][0];
          pkt_len[p]  = n;
          for (int k = 0; k < n; k++)
            pkt_bytes[p][k] = pat_mem[idx+5+k][7:0];
          idx = idx + 5 + n;
        end
        32'd2:
        begin
          send_packets();
          idx++;
        end
        32'd3:
        begin
          while (pat_mem[idx] == 32'd3)
          begin
            px_q.push_back(pat_mem[idx+1][6:0]);
            py_q.push_back(pat_mem[idx+2][4:0]);
            pc_q.push_back(pat_mem[idx+3][15:0]);
            idx = idx + 4;
          end
          run_pixels();
        end
        default:
        begin
          $display("Unknown record type %0h at word %0d of the pattern file",
                   pat_mem[idx], idx);
          stop_run();
        end
      endcase
    end
    $display("RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire

// ==== usb_hid_monitor_patterns.txt ====
// hex words. 1 port err accept count byte0.. | 2 send queued packets
// 3 x y colour | 0 end of patterns
3 01 00 ffff  3 00 00 0000  3 07 08 ffff  3 05 09 0000  3 0c 13 ffff  3 0e 17 0000
1 0 0 1 14 21 43 65 87 a9 cb ed 0f 55 55 55 55 55 55 55 55 55 55 55 55
2
3 02 00 ffff  3 01 00 0000  3 1b 02 ffff  3 1c 02 0000  3 3c 06 ffff
3 40 06 0000  3 54 06 ffff  3 55 06 0000  3 59 03 0000
1 1 0 1 14 8c 00 00 00 00 00 00 00 aa aa aa aa aa aa aa aa aa aa aa aa
2
3 00 0a ffff  3 04 0a 0000  3 06 0b 0000  3 07 0b ffff  3 0c 0a ffff  3 0d 0a 0000  3 10 0a ffff
1 2 0 1 14 3d 00 00 00 00 00 00 70 5a 5a 5a 5a 5a 5a 5a 5a 5a 5a 5a 5a
2
3 02 10 ffff  3 03 10 0000  3 09 11 ffff  3 08 11 0000  3 5b 16 ffff  3 5a 16 0000
1 0 0 0 05 11 22 33 44 55
2
1 0 1 0 14 66 66 66 66 66 66 66 66 66 66 66 66 66 66 66 66 66 66 66 66
2
3 02 00 ffff  3 19 02 ffff
1 0 0 1 08 5a 00 00 00 00 00 00 00
2
3 04 03 ffff  3 06 01 ffff  3 07 01 0000  3 19 02 0000  3 3c 06 0000
1 1 0 1 18 9b 00 00 00 00 00 00 00 ee ee ee ee ee ee ee ee ee ee ee ee ee ee ee ee
2
3 03 08 ffff  3 04 08 0000  3 07 0e ffff  3 09 0e 0000
1 0 0 1 08 66 00 00 00 00 00 00 00
1 1 0 1 0a 44 00 00 00 00 00 00 00 00 00
1 2 0 1 14 f2 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
2
3 02 00 ffff  3 01 00 0000  3 03 08 ffff  3 02 08 0000  3 00 16 ffff  3 06 16 ffff  3 07 16 0000
0

// ==== usb_hid_monitor.f ====
hid_mon_pkg.sv
hid_report_collector.sv
report_display_latch.sv
hex_font_rom.sv
hex_glyph_decoder.sv
usb_hid_monitor.sv
usb_hid_monitor_asserts.sv
tb_usb_hid_monitor.sv

// ==== Makefile ====
# Verilator build and run for the usb hid monitor testbench

VERILATOR ?= verilator
TOP       ?= tb_usb_hid_monitor
FILELIST  ?= usb_hid_monitor.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
SIM       ?= $(BUILD_DIR)/V$(TOP)

SRCS := $(shell grep -v '^+' $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(SIM)

clean:
	rm -rf $(BUILD_DIR)
